// ==== rtl/rv_core_pkg.sv ====
// data width, opcode/alu/branch/write-back enums and packed structs shared by the core
`default_nettype none

package rv_core_pkg;

    parameter int XLEN = 32;

    // major opcodes of the supported rv32i subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } rv_opcode_e;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_sra = 4'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none   = 3'd0,
        br_eq     = 3'd1,
        br_ne     = 3'd2,
        br_lt     = 3'd3,
        br_ge     = 3'd4,
        br_always = 3'd5    // jal
    } br_cond_e;

    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_load = 2'd1,
        wb_link = 2'd2      // pc + 4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e         alu_op;
        br_cond_e        br_cond;
        wb_sel_e         wb_sel;
        logic            reg_we;
        logic            mem_re;
        logic            mem_we;
        logic            use_imm;   // alu operand b from imm
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;
    } decode_ctrl_t;

    typedef struct packed {
        logic            we;
        logic [4:0]      addr;
        logic [XLEN-1:0] data;
    } rf_write_t;

    typedef struct packed {
        logic            re;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_res_t;

endpackage

`default_nettype wire

// ==== rtl/pc_unit.sv ====
// program counter register with reset address, step by four and redirect
`timescale 1ns/1ns
`default_nettype none

module pc_unit #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         redirect_valid,
    input  wire logic [rv_core_pkg::XLEN-1:0] redirect_target,
    output logic      [rv_core_pkg::XLEN-1:0] pc
);

    logic [rv_core_pkg::XLEN-1:0] pc_next;

    assign pc_next = redirect_valid ? redirect_target : pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;  // taken branch or jal wins over the step
        end
    end

    // branch and jal offsets are multiples of two only, so a bad program
    // or a bad target adder would show up here as a misaligned fetch
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
// instruction decoder producing the control struct and sign-extended immediate
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire logic [rv_core_pkg::XLEN-1:0] instruction,
    output rv_core_pkg::decode_ctrl_t         ctrl
);

    rv_core_pkg::rv_opcode_e      opcode;
    rv_core_pkg::alu_op_e         alu_fn;
    logic                         alu_ok;     // funct3/funct7 pair is supported
    logic                         is_reg;
    logic                         f7_zero;
    logic                         f7_alt;     // selects sub or sra
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    logic [rv_core_pkg::XLEN-1:0] imm_i;
    logic [rv_core_pkg::XLEN-1:0] imm_s;
    logic [rv_core_pkg::XLEN-1:0] imm_b;
    logic [rv_core_pkg::XLEN-1:0] imm_j;

    assign opcode  = rv_core_pkg::rv_opcode_e'(instruction[6:0]);
    assign funct3  = instruction[14:12];
    assign funct7  = instruction[31:25];
    assign is_reg  = (opcode == rv_core_pkg::op_reg);
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    // alu function for register and immediate ops
    always_comb begin
        alu_fn = rv_core_pkg::alu_add;
        alu_ok = 1'b1;
        case (funct3)
            3'b000: begin
                alu_fn = (is_reg && f7_alt) ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
                alu_ok = !is_reg || f7_zero || f7_alt;  // addi has no funct7
            end
            3'b001: begin
                alu_fn = rv_core_pkg::alu_sll;
                alu_ok = f7_zero;
            end
            3'b100: begin
                alu_fn = rv_core_pkg::alu_xor;
                alu_ok = !is_reg || f7_zero;
            end
            3'b101: begin
                alu_fn = f7_alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                alu_ok = f7_zero || f7_alt;
            end
            3'b110: begin
                alu_fn = rv_core_pkg::alu_or;
                alu_ok = !is_reg || f7_zero;
            end
            3'b111: begin
                alu_fn = rv_core_pkg::alu_and;
                alu_ok = !is_reg || f7_zero;
            end
            default: alu_ok = 1'b0;  // slt, sltu and their immediates
        endcase
    end

    always_comb begin
        ctrl.alu_op  = rv_core_pkg::alu_add;
        ctrl.br_cond = rv_core_pkg::br_none;
        ctrl.wb_sel  = rv_core_pkg::wb_alu;
        ctrl.reg_we  = 1'b0;
        ctrl.mem_re  = 1'b0;
        ctrl.mem_we  = 1'b0;
        ctrl.use_imm = 1'b0;
        ctrl.rd      = instruction[11:7];
        ctrl.rs1     = instruction[19:15];
        ctrl.rs2     = instruction[24:20];
        ctrl.imm     = imm_i;
        case (opcode)
            rv_core_pkg::op_reg: begin
                ctrl.alu_op = alu_fn;
                ctrl.reg_we = alu_ok;
            end
            rv_core_pkg::op_imm: begin
                ctrl.alu_op  = alu_fn;
                ctrl.reg_we  = alu_ok;
                ctrl.use_imm = 1'b1;
            end
            rv_core_pkg::op_load: begin
                ctrl.wb_sel  = rv_core_pkg::wb_load;
                ctrl.reg_we  = (funct3 == 3'b010);  // lw only
                ctrl.mem_re  = (funct3 == 3'b010);
                ctrl.use_imm = 1'b1;
            end
            rv_core_pkg::op_store: begin
                ctrl.mem_we  = (funct3 == 3'b010);  // sw only
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_s;
            end
            rv_core_pkg::op_branch: begin
                ctrl.imm = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_cond = rv_core_pkg::br_eq;
                    3'b001:  ctrl.br_cond = rv_core_pkg::br_ne;
                    3'b100:  ctrl.br_cond = rv_core_pkg::br_lt;
                    3'b101:  ctrl.br_cond = rv_core_pkg::br_ge;
                    default: ctrl.br_cond = rv_core_pkg::br_none;  // bltu, bgeu
                endcase
            end
            rv_core_pkg::op_jal: begin
                ctrl.br_cond = rv_core_pkg::br_always;
                ctrl.wb_sel  = rv_core_pkg::wb_link;
                ctrl.reg_we  = 1'b1;
                ctrl.imm     = imm_j;
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// 32 x 32 register file with two read ports, one write port and x0 tied to zero
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [4:0]                   rs1_addr,
    input  wire logic [4:0]                   rs2_addr,
    output logic      [rv_core_pkg::XLEN-1:0] rs1_data,
    output logic      [rv_core_pkg::XLEN-1:0] rs2_data,
    input  rv_core_pkg::rf_write_t            wr
);

    logic [rv_core_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;  // x0 writes dropped
        end
    end

    // old value is seen in the write cycle
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
// arithmetic and logic unit for add, sub, and, or, xor and the three shifts
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire logic [rv_core_pkg::XLEN-1:0] a,
    input  wire logic [rv_core_pkg::XLEN-1:0] b,
    input  rv_core_pkg::alu_op_e              op,
    output logic      [rv_core_pkg::XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // only the low five bits shift

    always_comb begin
        case (op)
            rv_core_pkg::alu_add: result = a + b;
            rv_core_pkg::alu_sub: result = a - b;
            rv_core_pkg::alu_and: result = a & b;
            rv_core_pkg::alu_or:  result = a | b;
            rv_core_pkg::alu_xor: result = a ^ b;
            rv_core_pkg::alu_sll: result = a << shamt;
            rv_core_pkg::alu_srl: result = a >> shamt;
            rv_core_pkg::alu_sra: result = $signed(a) >>> shamt;  // sign fill
            default:              result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/branch_unit.sv ====
// branch compare and pc-relative target for conditional branches and jal
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  wire logic [rv_core_pkg::XLEN-1:0] rs1_data,
    input  wire logic [rv_core_pkg::XLEN-1:0] rs2_data,
    input  wire logic [rv_core_pkg::XLEN-1:0] pc,
    input  wire logic [rv_core_pkg::XLEN-1:0] imm,
    input  rv_core_pkg::br_cond_e             cond,
    output rv_core_pkg::branch_res_t          res
);

    logic is_eq;
    logic is_lt;

    assign is_eq = (rs1_data == rs2_data);
    assign is_lt = ($signed(rs1_data) < $signed(rs2_data));  // signed compare for blt/bge

    always_comb begin
        case (cond)
            rv_core_pkg::br_eq:     res.taken = is_eq;
            rv_core_pkg::br_ne:     res.taken = !is_eq;
            rv_core_pkg::br_lt:     res.taken = is_lt;
            rv_core_pkg::br_ge:     res.taken = !is_lt;
            rv_core_pkg::br_always: res.taken = 1'b1;
            default:                res.taken = 1'b0;
        endcase
    end

    // same adder for branches and jal, imm already carries the right format
    assign res.target = pc + imm;

endmodule

`default_nettype wire

// ==== rtl/commit_stage.sv ====
// commit logic forming the register write, data memory request and pc redirect
`timescale 1ns/1ns
`default_nettype none

module commit_stage (
    input  wire logic                         rst_n,
    input  rv_core_pkg::decode_ctrl_t         ctrl,
    input  wire logic [rv_core_pkg::XLEN-1:0] alu_result,
    input  wire logic [rv_core_pkg::XLEN-1:0] rs2_data,
    input  wire logic [rv_core_pkg::XLEN-1:0] pc,
    input  wire logic [rv_core_pkg::XLEN-1:0] dmem_rdata,
    input  rv_core_pkg::branch_res_t          br,
    output rv_core_pkg::rf_write_t            rf_write,
    output rv_core_pkg::dmem_req_t            dmem_req,
    output logic                              redirect_valid,
    output logic      [rv_core_pkg::XLEN-1:0] redirect_target
);

    logic [rv_core_pkg::XLEN-1:0] link_addr;
    logic [rv_core_pkg::XLEN-1:0] wb_data;

    assign link_addr = pc + 32'd4;  // return address for jal

    always_comb begin
        case (ctrl.wb_sel)
            rv_core_pkg::wb_load: wb_data = dmem_rdata;
            rv_core_pkg::wb_link: wb_data = link_addr;
            default:              wb_data = alu_result;
        endcase
    end

    assign rf_write.we   = ctrl.reg_we & rst_n;
    assign rf_write.addr = ctrl.rd;
    assign rf_write.data = wb_data;

    // lw and sw address both come from rs1 + imm through the alu
    assign dmem_req.re    = ctrl.mem_re & rst_n;
    assign dmem_req.we    = ctrl.mem_we & rst_n;
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;

    assign redirect_valid  = br.taken;
    assign redirect_target = br.target;

    // the decoder never raises both for one opcode
    always_comb begin
        assert (!(dmem_req.re && dmem_req.we))
            else $error("load and store requested together");
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core_top.sv ====
// top level of the single-cycle rv32i core with the alu operand select
`timescale 1ns/1ns
`default_nettype none

module rv_core_top #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    output logic      [rv_core_pkg::XLEN-1:0] pc,
    input  wire logic [rv_core_pkg::XLEN-1:0] instruction,
    output rv_core_pkg::dmem_req_t            dmem_req,
    input  wire logic [rv_core_pkg::XLEN-1:0] dmem_rdata,
    output rv_core_pkg::rf_write_t            rf_write
);

    rv_core_pkg::decode_ctrl_t    ctrl;
    rv_core_pkg::branch_res_t     br_res;
    logic [rv_core_pkg::XLEN-1:0] rs1_data;
    logic [rv_core_pkg::XLEN-1:0] rs2_data;
    logic [rv_core_pkg::XLEN-1:0] alu_b;
    logic [rv_core_pkg::XLEN-1:0] alu_result;
    logic                         redirect_valid;
    logic [rv_core_pkg::XLEN-1:0] redirect_target;

    pc_unit #(
        .RESET_PC(RESET_PC)
    ) pc_unit0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target),
        .pc             (pc)
    );

    instr_decoder instr_decoder0 (
        .instruction(instruction),
        .ctrl       (ctrl)
    );

    reg_file reg_file0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_addr(ctrl.rs1),
        .rs2_addr(ctrl.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr      (rf_write)
    );

    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;  // imm ops, lw and sw

    alu alu0 (
        .a     (rs1_data),
        .b     (alu_b),
        .op    (ctrl.alu_op),
        .result(alu_result)
    );

    branch_unit branch_unit0 (
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .pc      (pc),
        .imm     (ctrl.imm),
        .cond    (ctrl.br_cond),
        .res     (br_res)
    );

    commit_stage commit_stage0 (
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .alu_result     (alu_result),
        .rs2_data       (rs2_data),
        .pc             (pc),
        .dmem_rdata     (dmem_rdata),
        .br             (br_res),
        .rf_write       (rf_write),
        .dmem_req       (dmem_req),
        .redirect_valid (redirect_valid),
        .redirect_target(redirect_target)
    );

endmodule

`default_nettype wire

// ==== bench/tb_checker.sv ====
// instruction-set reference model comparing each fetch, register write and store
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
    parameter logic [31:0] RESET_PC = '0
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic [31:0]      pc,
    input  wire logic [31:0]      instruction,
    input  rv_core_pkg::dmem_req_t dmem_req,
    input  rv_core_pkg::rf_write_t rf_write,
    output int                    mismatches,
    output int                    retired
);

    logic [31:0] model_regs [32];
    logic [31:0] model_mem [256];
    logic [31:0] model_pc;

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t %s: dut %h, model %h", $time, name, got, want);
            mismatches++;
        end
    endtask

    task automatic retire_one();
        logic [31:0] w, a, b, opb, wb, addr, next_pc;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic [2:0]  f3;
        logic        is_reg, alt, alu_ok, want_we, want_re, want_st, taken;
        w       = instruction;
        f3      = w[14:12];
        a       = model_regs[w[19:15]];
        b       = model_regs[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        is_reg  = (w[6:0] == 7'b0110011);
        alt     = (w[31:25] == 7'h20);
        opb     = is_reg ? b : imm_i;
        // funct7 zero, or the alternate form for sub, srl and sra only
        alu_ok  = f3[2:1] != 2'b01 && (w[31:25] == 7'h00
                  || (alt && (f3 == 3'b101 || (is_reg && f3 == 3'b000)))
                  || (!is_reg && f3 != 3'b001 && f3 != 3'b101));
        case (f3)
            3'b000:  wb = (is_reg && alt) ? a - opb : a + opb;
            3'b001:  wb = a << opb[4:0];
            3'b100:  wb = a ^ opb;
            3'b101: begin
                if (alt) wb = $signed(a) >>> opb[4:0];
                else wb = a >> opb[4:0];
            end
            3'b110:  wb = a | opb;
            default: wb = a & opb;
        endcase
        want_we = 1'b0;
        want_re = 1'b0;
        want_st = 1'b0;
        taken   = 1'b0;
        addr    = a + imm_i;
        next_pc = model_pc + 32'd4;
        case (w[6:0])
            7'b0110011, 7'b0010011: want_we = alu_ok;
            7'b0000011: begin
                want_we = (f3 == 3'b010);
                want_re = want_we;
                wb      = model_mem[addr[9:2]];
            end
            7'b0100011: begin
                want_st = (f3 == 3'b010);
                addr    = a + imm_s;
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;  // bltu and bgeu fall through
                endcase
                if (taken) next_pc = model_pc + imm_b;
            end
            7'b1101111: begin
                want_we = 1'b1;
                wb      = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
            end
            default: ;
        endcase
        compare_word("pc", pc, model_pc);
        compare_word("rf_write.we", {31'd0, rf_write.we}, {31'd0, want_we});
        if (want_we) begin
            compare_word("rf_write.addr", {27'd0, rf_write.addr}, {27'd0, w[11:7]});
            compare_word("rf_write.data", rf_write.data, wb);
        end
        compare_word("dmem_req.we", {31'd0, dmem_req.we}, {31'd0, want_st});
        compare_word("dmem_req.re", {31'd0, dmem_req.re}, {31'd0, want_re});
        if (want_st || want_re) compare_word("dmem_req.addr", dmem_req.addr, addr);
        if (want_st) compare_word("dmem_req.wdata", dmem_req.wdata, b);
        if (want_we && w[11:7] != 5'd0) model_regs[w[11:7]] = wb;  // x0 stays zero
        if (want_st) model_mem[addr[9:2]] = b;
        model_pc = next_pc;
        retired++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            compare_word("pc", pc, RESET_PC);
            compare_word("rf_write.we", {31'd0, rf_write.we}, 32'd0);
            compare_word("dmem_req.we", {31'd0, dmem_req.we}, 32'd0);
            compare_word("dmem_req.re", {31'd0, dmem_req.re}, 32'd0);
            model_pc = RESET_PC;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            for (int i = 0; i < 256; i++) begin
                model_mem[i] = 32'hc0de_0000 | i;  // same fill as the bench memory
            end
        end else begin
            retire_one();
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_top.sv ====
// testbench top with clock, reset, random program, memory models, core and checker
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam logic [31:0] RESET_PC     = 32'h0;
    localparam logic [31:0] SEED         = 32'h2323;
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;  // addi x0, x0, 0
    localparam int          PROG_LEN     = 64;
    localparam int          RESET_CYCLES = 5;
    localparam int          RUN_CYCLES   = 200;
    localparam int          RUN_TIMEOUT  = 400;

    // {alternate funct7, funct3} for add sub and or xor sll srl sra
    localparam logic [3:0] ALU_FN [8] = '{4'h0, 4'h8, 4'h7, 4'h6, 4'h4, 4'h1, 4'h5, 4'hd};

    // sw x2, 0(x1) then lw x3, 0(x1) then addi x5, x0, 1 at the reset address
    localparam logic [31:0] RESET_WORDS [3] = '{32'h0020_a023, 32'h0000_a183, 32'h0010_0293};

    logic                   clk;
    logic                   rst_n;
    logic [31:0]            pc;
    logic [31:0]            instruction = NOP_WORD;
    logic [31:0]            dmem_rdata = '0;
    rv_core_pkg::dmem_req_t dmem_req;
    rv_core_pkg::rf_write_t rf_write;
    logic [31:0]            prog [PROG_LEN];
    logic [31:0]            dmem [256];
    int                     mismatches;
    int                     retired;
    int                     bench_errors;

    rv_core_top #(.RESET_PC(RESET_PC)) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .instruction(instruction),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .rf_write   (rf_write)
    );

    tb_checker #(.RESET_PC(RESET_PC)) checker0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .instruction(instruction),
        .dmem_req   (dmem_req),
        .rf_write   (rf_write),
        .mismatches (mismatches),
        .retired    (retired)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x1 is the memory base and is written only by the first instruction
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  fn;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] off;
        logic [11:0] mem_off;
        prog[0] = {12'd64, 5'd0, 3'b000, 5'd1, 7'b0010011};
        for (int i = 1; i < PROG_LEN; i++) begin
            r       = $urandom;
            s       = $urandom;
            fn      = ALU_FN[r[22:20]];
            rd      = (r[11:8] == 4'd1) ? 5'd0 : {1'b0, r[11:8]};
            rs1     = {1'b0, r[15:12]};
            rs2     = {1'b0, r[19:16]};
            off     = {8'd0, {1'b0, r[25:24]} + 3'd1, 2'b00};  // 1 to 4 words ahead
            mem_off = {6'd0, s[15:12], 2'b00};
            case (r[31:28])
                4'd0, 4'd1, 4'd2, 4'd3:
                    prog[i] = {1'b0, fn[3], 5'd0, rs2, rs1, fn[2:0], rd, 7'b0110011};
                4'd4, 4'd5, 4'd6, 4'd7:
                    prog[i] = {(fn[1:0] == 2'b01) ? {1'b0, fn[3], 5'd0, s[4:0]} : s[11:0],
                               rs1, fn[2:0], rd, 7'b0010011};  // sub slot becomes addi
                4'd8, 4'd9:
                    prog[i] = {mem_off, 5'd1, 3'b010, rd, 7'b0000011};
                4'd10, 4'd11:
                    prog[i] = {mem_off[11:5], rs2, 5'd1, 3'b010, mem_off[4:0], 7'b0100011};
                4'd12, 4'd13:
                    prog[i] = {off[12], off[10:5], rs2, rs1, r[21], 1'b0, r[20], off[4:1],
                               off[11], 7'b1100011};  // beq bne blt bge
                4'd14:
                    prog[i] = {1'b0, off[10:1], off[11], 8'd0, rd, 7'b1101111};
                default:
                    prog[i] = r[20] ? {s[31:12], rd, 7'b0110111}  // lui and slt are no-ops
                                    : {7'd0, rs2, rs1, 3'b010, rd, 7'b0110011};
            endcase
        end
    endtask

    // instruction first, then load data once the request has settled
    always @(negedge clk) begin
        instruction = (pc[31:8] == 24'd0) ? prog[pc[7:2]] : NOP_WORD;
        #1;
        dmem_rdata = dmem[dmem_req.addr[9:2]];
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 32'hc0de_0000 | i;
            end
        end else if (dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    initial begin
        int cycles;
        void'($urandom(SEED));
        rst_n = 1'b0;
        for (cycles = 0; cycles < RESET_CYCLES; cycles++) begin
            prog[0] = RESET_WORDS[cycles % 3];  // store, load and write held off by reset
            @(posedge clk);
        end
        build_program();
        @(negedge clk);
        rst_n = 1'b1;
        cycles = 0;
        while (retired < RUN_CYCLES && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < RUN_CYCLES) begin
            $display("timeout: only %0d of %0d instructions retired", retired, RUN_CYCLES);
            bench_errors++;
        end
        $display("closing: %0d model mismatches, %0d bench failures", mismatches, bench_errors);
        if (mismatches == 0 && bench_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/rv_core_pkg.sv
rtl/pc_unit.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/commit_stage.sv
rtl/rv_core_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= test failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
